/* hdl/biquad_pkg.sv */
// --------------------------------------------------------------------------
// Shared types and register map of the biquad filter
// Coefficients are Q2.14, so the usable range is -2.0 up to just below 2.0
// --------------------------------------------------------------------------

package biquad_pkg;

    // Datapath widths
    typedef logic signed [15:0] sample_t;
    typedef logic signed [15:0] coef_t;
    typedef logic [31:0]        count_t;

    // APB bus widths
    typedef logic [11:0]        apb_addr_t;
    typedef logic [31:0]        apb_data_t;

    // Fraction bits of a Q2.14 coefficient
    localparam int COEF_FRAC_BITS = 14;

    // ----------------------------------------------------------------------
    // Register offsets in bytes from the base address
    // ----------------------------------------------------------------------
    localparam apb_addr_t REG_B0_OFFS    = 12'h000;
    localparam apb_addr_t REG_B1_OFFS    = 12'h004;
    localparam apb_addr_t REG_B2_OFFS    = 12'h008;
    localparam apb_addr_t REG_A1_OFFS    = 12'h00C;
    localparam apb_addr_t REG_A2_OFFS    = 12'h010;
    localparam apb_addr_t REG_CTRL_OFFS  = 12'h014;
    localparam apb_addr_t REG_COUNT_OFFS = 12'h020;
    localparam apb_addr_t REG_LAST_OFFS  = 12'h024;
    localparam apb_addr_t REG_SAT_OFFS   = 12'h028;

    // Filter configuration, 81 bits
    typedef struct packed {
        coef_t b0;
        coef_t b1;
        coef_t b2;
        coef_t a1;
        coef_t a2;
        logic  bypass;
    } coef_set_t;

    // Datapath status, 80 bits
    typedef struct packed {
        count_t  sample_count;
        sample_t last_out;
        count_t  sat_count;
    } biquad_status_t;

endpackage

/* hdl/biquad_apb_regs.sv */
// --------------------------------------------------------------------------
// APB3 register block, no PSLVERR, fixed single wait state per transfer
// Unmapped offsets read zero and ignore writes
// --------------------------------------------------------------------------

module biquad_apb_regs #(
    parameter biquad_pkg::apb_addr_t APB_BASE_ADDR = 12'h000
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // APB3 slave
    input  biquad_pkg::apb_addr_t      paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  biquad_pkg::apb_data_t      pwdata,
    output logic                       pready,
    output biquad_pkg::apb_data_t      prdata,

    // Configuration out, status in
    output biquad_pkg::coef_set_t      cfg,
    input  biquad_pkg::biquad_status_t status
);

    // Access phase seen, ready not yet given
    logic                  access;
    // Completing cycle of a write
    logic                  wr_done;
    biquad_pkg::apb_data_t rd_mux;

    assign access  = psel && penable && !pready;
    assign wr_done = psel && penable && pready && pwrite;

    // ----------------------------------------------------------------------
    // Read mux
    // ----------------------------------------------------------------------
    always_comb begin
        rd_mux = '0;
        case (paddr)
            APB_BASE_ADDR + biquad_pkg::REG_B0_OFFS:    rd_mux = {16'h0000, cfg.b0};
            APB_BASE_ADDR + biquad_pkg::REG_B1_OFFS:    rd_mux = {16'h0000, cfg.b1};
            APB_BASE_ADDR + biquad_pkg::REG_B2_OFFS:    rd_mux = {16'h0000, cfg.b2};
            APB_BASE_ADDR + biquad_pkg::REG_A1_OFFS:    rd_mux = {16'h0000, cfg.a1};
            APB_BASE_ADDR + biquad_pkg::REG_A2_OFFS:    rd_mux = {16'h0000, cfg.a2};
            APB_BASE_ADDR + biquad_pkg::REG_CTRL_OFFS:  rd_mux = {31'd0, cfg.bypass};
            APB_BASE_ADDR + biquad_pkg::REG_COUNT_OFFS: rd_mux = status.sample_count;
            // Last output goes out sign-extended
            APB_BASE_ADDR + biquad_pkg::REG_LAST_OFFS:
                rd_mux = {{16{status.last_out[15]}}, status.last_out};
            APB_BASE_ADDR + biquad_pkg::REG_SAT_OFFS:   rd_mux = status.sat_count;
            default:                                    rd_mux = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Ready, read data and configuration registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pready <= 1'b0;
            prdata <= '0;
            cfg    <= '0;
        end else begin
            // Ready and data are single-cycle pulses
            pready <= 1'b0;
            prdata <= '0;

            if (access) begin
                pready <= 1'b1;
                if (!pwrite) begin
                    prdata <= rd_mux;
                end
            end

            // Write lands on the edge that ends the transfer
            if (wr_done) begin
                case (paddr)
                    APB_BASE_ADDR + biquad_pkg::REG_B0_OFFS: cfg.b0 <= pwdata[15:0];
                    APB_BASE_ADDR + biquad_pkg::REG_B1_OFFS: cfg.b1 <= pwdata[15:0];
                    APB_BASE_ADDR + biquad_pkg::REG_B2_OFFS: cfg.b2 <= pwdata[15:0];
                    APB_BASE_ADDR + biquad_pkg::REG_A1_OFFS: cfg.a1 <= pwdata[15:0];
                    APB_BASE_ADDR + biquad_pkg::REG_A2_OFFS: cfg.a2 <= pwdata[15:0];
                    APB_BASE_ADDR + biquad_pkg::REG_CTRL_OFFS: cfg.bypass <= pwdata[0];
                    // Status offsets are read only
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hdl/biquad_in_fifo.sv */
// --------------------------------------------------------------------------
// Input sample buffer, upstream must hold a credit to send
// A write into a full buffer is dropped
// --------------------------------------------------------------------------

module biquad_in_fifo #(
    parameter int IN_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  biquad_pkg::sample_t in_sample,
    input  logic                pop,
    output logic                fifo_valid,
    output biquad_pkg::sample_t fifo_sample,
    output logic                in_credit
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    biquad_pkg::sample_t mem [IN_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                wr_en;
    logic                rd_en;

    assign fifo_valid  = (count != '0);
    assign fifo_sample = mem[rd_ptr];
    assign wr_en       = in_valid && (count != CNT_W'(IN_DEPTH));
    assign rd_en       = pop && fifo_valid;

    // Storage, no reset needed on the payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_sample;
        end
    end

    // Pointers wrap at IN_DEPTH, so any depth works
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back to upstream for each pop
            in_credit <= rd_en;
        end
    end

endmodule

/* hdl/biquad_df1_core.sv */
// --------------------------------------------------------------------------
// Direct form I biquad, one sample per cycle, Q2.14 coefficients
// Output saturates to 16 bits; bypass passes x through and keeps history
// --------------------------------------------------------------------------

module biquad_df1_core #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  biquad_pkg::coef_set_t      cfg,
    input  logic                       fifo_valid,
    input  biquad_pkg::sample_t        fifo_sample,
    output logic                       pop,
    output logic                       out_valid,
    output biquad_pkg::sample_t        out_sample,
    input  logic                       out_credit,
    output biquad_pkg::biquad_status_t status
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);
    localparam logic signed [35:0] SAT_MAX = 36'sd32767;
    localparam logic signed [35:0] SAT_MIN = -36'sd32768;

    // Filter history
    biquad_pkg::sample_t x1;
    biquad_pkg::sample_t x2;
    biquad_pkg::sample_t y1;
    biquad_pkg::sample_t y2;

    logic signed [35:0]  acc;
    logic signed [35:0]  acc_shr;
    logic                sat_hi;
    logic                sat_lo;
    biquad_pkg::sample_t y_filt;
    biquad_pkg::sample_t y_next;
    logic [CRED_W-1:0]   credit_cnt;

    // ----------------------------------------------------------------------
    // Arithmetic
    // ----------------------------------------------------------------------
    // All operands signed, so each product is sign-extended to 36 bits
    assign acc = $signed(cfg.b0) * $signed(fifo_sample)
               + $signed(cfg.b1) * $signed(x1)
               + $signed(cfg.b2) * $signed(x2)
               - $signed(cfg.a1) * $signed(y1)
               - $signed(cfg.a2) * $signed(y2);

    // Back to sample scale
    assign acc_shr = acc >>> biquad_pkg::COEF_FRAC_BITS;
    assign sat_hi  = (acc_shr > SAT_MAX);
    assign sat_lo  = (acc_shr < SAT_MIN);

    always_comb begin
        if (sat_hi) begin
            y_filt = 16'sh7FFF;
        end else if (sat_lo) begin
            y_filt = 16'sh8000;
        end else begin
            y_filt = acc_shr[15:0];
        end
    end

    assign y_next = cfg.bypass ? fifo_sample : y_filt;

    // ----------------------------------------------------------------------
    // Flow control
    // ----------------------------------------------------------------------
    // A sample in out_valid still holds its credit, so count it as spent
    assign pop = fifo_valid && (credit_cnt > CRED_W'(out_valid));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CRED_W'(OUT_CREDITS);
        end else begin
            // Return and send in one cycle leave the count unchanged
            case ({out_credit, out_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // History, output and status
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1        <= '0;
            x2        <= '0;
            y1        <= '0;
            y2        <= '0;
            out_valid <= 1'b0;
            status    <= '0;
        end else begin
            out_valid <= pop;
            if (pop) begin
                // History shifts in every mode
                x2 <= x1;
                x1 <= fifo_sample;
                y2 <= y1;
                y1 <= y_next;
                status.last_out     <= y_next;
                status.sample_count <= status.sample_count + 1'b1;
                if (!cfg.bypass && (sat_hi || sat_lo)) begin
                    status.sat_count <= status.sat_count + 1'b1;
                end
            end
        end
    end

    // Output register is the last_out status field
    assign out_sample = status.last_out;

endmodule

/* hdl/biquad_top.sv */
// --------------------------------------------------------------------------
// Biquad filter top, APB3 configuration and credit-based sample streams
// Upstream starts with IN_DEPTH credits, downstream owns OUT_CREDITS slots
// --------------------------------------------------------------------------

module biquad_top #(
    parameter biquad_pkg::apb_addr_t APB_BASE_ADDR = 12'h000,
    parameter int                    IN_DEPTH      = 4,
    parameter int                    OUT_CREDITS   = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // APB3
    input  biquad_pkg::apb_addr_t paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  biquad_pkg::apb_data_t pwdata,
    output logic                  pready,
    output biquad_pkg::apb_data_t prdata,

    // Sample in
    input  logic                  in_valid,
    input  biquad_pkg::sample_t   in_sample,
    output logic                  in_credit,

    // Sample out
    output logic                  out_valid,
    output biquad_pkg::sample_t   out_sample,
    input  logic                  out_credit
);

    biquad_pkg::coef_set_t      cfg;
    biquad_pkg::biquad_status_t status;
    logic                       pop;
    logic                       fifo_valid;
    biquad_pkg::sample_t        fifo_sample;

    // Register block
    biquad_apb_regs #(
        .APB_BASE_ADDR (APB_BASE_ADDR)
    ) i_apb_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pready  (pready),
        .prdata  (prdata),
        .cfg     (cfg),
        .status  (status)
    );

    // Input buffer
    biquad_in_fifo #(
        .IN_DEPTH (IN_DEPTH)
    ) i_in_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_sample   (in_sample),
        .pop         (pop),
        .fifo_valid  (fifo_valid),
        .fifo_sample (fifo_sample),
        .in_credit   (in_credit)
    );

    // Filter datapath
    biquad_df1_core #(
        .OUT_CREDITS (OUT_CREDITS)
    ) i_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .fifo_valid  (fifo_valid),
        .fifo_sample (fifo_sample),
        .pop         (pop),
        .out_valid   (out_valid),
        .out_sample  (out_sample),
        .out_credit  (out_credit),
        .status      (status)
    );

endmodule

/* testbench/biquad_sva.sv */
// --------------------------------------------------------------------------
// Flow control and APB ready properties, bound into biquad_top
// Reaches the credit counter and buffer occupancy by hierarchical name
// --------------------------------------------------------------------------

module biquad_sva #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input logic                               clk,
    input logic                               rst_n,
    input logic                               out_valid,
    input logic                               in_valid,
    input logic                               pready,
    input logic [$clog2(OUT_CREDITS + 1)-1:0] credit_cnt,
    input logic [$clog2(IN_DEPTH + 1)-1:0]    fifo_count
);

    // A sample on the output still holds its credit, so the count is nonzero
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> credit_cnt != 0)
        else $error("out_valid high with no output credit");

    // Upstream never sends into a full buffer
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> fifo_count != IN_DEPTH)
        else $error("in_valid while the input buffer is full");

    // Ready is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n) pready |=> !pready)
        else $error("pready high for two cycles in a row");

endmodule

bind biquad_top biquad_sva #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) i_biquad_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .in_valid   (in_valid),
    .pready     (pready),
    .credit_cnt (i_core.credit_cnt),
    .fifo_count (i_in_fifo.count)
);

/* testbench/tb_biquad.sv */
// --------------------------------------------------------------------------
// Directed tests of the biquad top, APB base address 0x000
// Sink returns one credit per sample unless credits are withheld
// --------------------------------------------------------------------------

module tb_biquad;

    localparam biquad_pkg::apb_addr_t BASE = 12'h000;
    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    // About 90 samples and 50 register accesses need near 1500 time units
    localparam int TIMEOUT     = 20000;

    logic                  clk;
    logic                  rst_n;
    biquad_pkg::apb_addr_t paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    biquad_pkg::apb_data_t pwdata;
    logic                  pready;
    biquad_pkg::apb_data_t prdata;
    logic                  in_valid;
    biquad_pkg::sample_t   in_sample;
    logic                  in_credit;
    logic                  out_valid;
    biquad_pkg::sample_t   out_sample;
    logic                  out_credit;

    // Scoreboard and stream bookkeeping
    int    errors       = 0;
    string test_name    = "none";
    int    expected_q[$];
    int    sent_total   = 0;
    int    credits_back = 0;
    int    received     = 0;
    int    owed         = 0;
    logic  hold_credits = 1'b0;
    int    last_expected = 0;

    // Model coefficients, history and saturation count
    int    m_b0;
    int    m_b1;
    int    m_b2;
    int    m_a1;
    int    m_a2;
    logic  m_bypass = 1'b0;
    int    m_x1 = 0;
    int    m_x2 = 0;
    int    m_y1 = 0;
    int    m_y2 = 0;
    int    model_sats = 0;

    biquad_top #(
        .APB_BASE_ADDR (BASE),
        .IN_DEPTH      (IN_DEPTH),
        .OUT_CREDITS   (OUT_CREDITS)
    ) i_biquad_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .pready     (pready),
        .prdata     (prdata),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // Monitors
    // ----------------------------------------------------------------------
    // Credits back to upstream, registered value seen before the edge
    always @(posedge clk) begin
        if (in_credit) begin
            credits_back++;
        end
    end

    // Output check and credit return to the core
    always @(negedge clk) begin
        int exp_out;
        out_credit = 1'b0;
        if (rst_n && out_valid) begin
            received++;
            if (expected_q.size() == 0) begin
                errors++;
                $display("Output sample %0d in %s arrived with none pending",
                         out_sample, test_name);
            end else begin
                exp_out = expected_q.pop_front();
                if (int'(out_sample) != exp_out) begin
                    errors++;
                    $display("Error %s: expected %0d, actual %0d",
                             test_name, exp_out, out_sample);
                end
            end
            if (hold_credits) begin
                owed++;
            end else begin
                out_credit = 1'b1;
            end
        end else if (rst_n && !hold_credits && owed > 0) begin
            // Withheld credits go back one per cycle
            out_credit = 1'b1;
            owed--;
        end
    end

    // ----------------------------------------------------------------------
    // Model and bus tasks
    // ----------------------------------------------------------------------
    // One DF1 step in Q2.14, history shifts in every mode
    function automatic int filter_model(input int x);
        longint acc;
        longint y;
        acc = longint'(m_b0) * x + longint'(m_b1) * m_x1 + longint'(m_b2) * m_x2
            - longint'(m_a1) * m_y1 - longint'(m_a2) * m_y2;
        y = acc >>> 14;
        if (m_bypass) begin
            y = x;
        end else if (y > 32767) begin
            y = 32767;
            model_sats++;
        end else if (y < -32768) begin
            y = -32768;
            model_sats++;
        end
        m_x2 = m_x1;
        m_x1 = x;
        m_y2 = m_y1;
        m_y1 = int'(y);
        return int'(y);
    endfunction

    // Setup, access, wait for ready, then one more edge to complete
    task automatic bus_transfer(input biquad_pkg::apb_addr_t addr, input logic write,
                                input biquad_pkg::apb_data_t wdata,
                                output biquad_pkg::apb_data_t rdata);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input biquad_pkg::apb_addr_t offs,
                             input biquad_pkg::apb_data_t data);
        biquad_pkg::apb_data_t unused;
        bus_transfer(BASE + offs, 1'b1, data, unused);
    endtask

    task automatic expect_reg(input biquad_pkg::apb_addr_t offs,
                              input biquad_pkg::apb_data_t exp);
        biquad_pkg::apb_data_t act;
        bus_transfer(BASE + offs, 1'b0, '0, act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: reg 0x%03h expected 0x%08h, actual 0x%08h",
                     test_name, offs, exp, act);
        end
    endtask

    task automatic set_coefs(input int b0, input int b1, input int b2,
                             input int a1, input int a2, input logic bypass);
        write_reg(biquad_pkg::REG_B0_OFFS, biquad_pkg::apb_data_t'(b0));
        write_reg(biquad_pkg::REG_B1_OFFS, biquad_pkg::apb_data_t'(b1));
        write_reg(biquad_pkg::REG_B2_OFFS, biquad_pkg::apb_data_t'(b2));
        write_reg(biquad_pkg::REG_A1_OFFS, biquad_pkg::apb_data_t'(a1));
        write_reg(biquad_pkg::REG_A2_OFFS, biquad_pkg::apb_data_t'(a2));
        write_reg(biquad_pkg::REG_CTRL_OFFS, {31'd0, bypass});
        m_b0     = b0;
        m_b1     = b1;
        m_b2     = b2;
        m_a1     = a1;
        m_a2     = a2;
        m_bypass = bypass;
    endtask

    // Called on a falling edge, sends only while upstream holds a credit
    task automatic send_sample(input int x);
        while (IN_DEPTH + credits_back - sent_total <= 0) @(negedge clk);
        in_valid      = 1'b1;
        in_sample     = biquad_pkg::sample_t'(x);
        last_expected = filter_model(x);
        expected_q.push_back(last_expected);
        sent_total++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int n);
        biquad_pkg::sample_t s;
        for (int i = 0; i < n; i++) begin
            s = 16'($urandom);
            send_sample(int'(s));
        end
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    task automatic reset_and_readback();
        biquad_pkg::apb_data_t w;
        biquad_pkg::apb_addr_t offs [6];
        test_name = "reset_and_readback";
        offs = '{biquad_pkg::REG_B0_OFFS, biquad_pkg::REG_B1_OFFS, biquad_pkg::REG_B2_OFFS,
                 biquad_pkg::REG_A1_OFFS, biquad_pkg::REG_A2_OFFS, biquad_pkg::REG_CTRL_OFFS};
        foreach (offs[i]) expect_reg(offs[i], '0);
        expect_reg(biquad_pkg::REG_COUNT_OFFS, '0);
        expect_reg(biquad_pkg::REG_LAST_OFFS, '0);
        expect_reg(biquad_pkg::REG_SAT_OFFS, '0);
        // Coefficients keep 16 bits, control keeps bit 0
        for (int i = 0; i < 5; i++) begin
            w = $urandom;
            write_reg(offs[i], w);
            expect_reg(offs[i], {16'h0000, w[15:0]});
        end
        w = $urandom;
        write_reg(biquad_pkg::REG_CTRL_OFFS, w);
        expect_reg(biquad_pkg::REG_CTRL_OFFS, {31'd0, w[0]});
    endtask

    task automatic unity_gain_stream();
        test_name = "unity_gain_stream";
        set_coefs(16384, 0, 0, 0, 0, 1'b0);
        send_random(20);
        wait_drain();
    endtask

    task automatic random_coef_stream();
        test_name = "random_coef_stream";
        // Gain above 1.0 with full-scale input drives the output into saturation
        set_coefs(16384 + int'($urandom % 8192), int'($urandom % 16384) - 8192,
                  int'($urandom % 8192) - 4096, int'($urandom % 16384) - 8192,
                  int'($urandom % 8192) - 4096, 1'b0);
        send_random(50);
        wait_drain();
        if (model_sats == 0) begin
            errors++;
            $display("No output saturated in %s, so saturation was not exercised",
                     test_name);
        end
        expect_reg(biquad_pkg::REG_SAT_OFFS, biquad_pkg::apb_data_t'(model_sats));
    endtask

    task automatic bypass_and_status();
        test_name = "bypass_and_status";
        set_coefs(5000, -3000, 2000, 1000, -500, 1'b1);
        send_random(10);
        wait_drain();
        expect_reg(biquad_pkg::REG_COUNT_OFFS, biquad_pkg::apb_data_t'(sent_total));
        expect_reg(biquad_pkg::REG_LAST_OFFS, biquad_pkg::apb_data_t'(last_expected));
    endtask

    task automatic credit_backpressure();
        int rx0;
        int cb0;
        int tx0;
        int n;
        test_name = "credit_backpressure";
        set_coefs(8192, 4096, 2048, -4096, 1024, 1'b0);
        n   = IN_DEPTH + OUT_CREDITS + 3;
        rx0 = received;
        cb0 = credits_back;
        tx0 = sent_total;
        hold_credits = 1'b1;
        fork
            send_random(n);
        join_none
        repeat (40) @(negedge clk);
        // Core stalls after its credits, buffer fills, upstream runs dry
        if (received - rx0 != OUT_CREDITS) begin
            errors++;
            $display("Error %s: expected %0d samples out, actual %0d",
                     test_name, OUT_CREDITS, received - rx0);
        end
        if (credits_back - cb0 != OUT_CREDITS) begin
            errors++;
            $display("Error %s: expected %0d input credits, actual %0d",
                     test_name, OUT_CREDITS, credits_back - cb0);
        end
        if (sent_total - tx0 != IN_DEPTH + OUT_CREDITS) begin
            errors++;
            $display("Error %s: expected %0d samples sent, actual %0d",
                     test_name, IN_DEPTH + OUT_CREDITS, sent_total - tx0);
        end
        hold_credits = 1'b0;
        wait (sent_total - tx0 == n);
        wait_drain();
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_sample = '0;
        out_credit = 1'b0;
        void'($urandom(47));
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_and_readback();
        unity_gain_stream();
        random_coef_stream();
        bypass_and_status();
        credit_backpressure();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired after %0d time units, the DUT stopped responding",
                 TIMEOUT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog.f */
hdl/biquad_pkg.sv
hdl/biquad_apb_regs.sv
hdl/biquad_in_fifo.sv
hdl/biquad_df1_core.sv
hdl/biquad_top.sv
testbench/biquad_sva.sv
testbench/tb_biquad.sv

/* Bender.yml */
package:
  name: biquad

sources:
  - files:
      - hdl/biquad_pkg.sv
      - hdl/biquad_apb_regs.sv
      - hdl/biquad_in_fifo.sv
      - hdl/biquad_df1_core.sv
      - hdl/biquad_top.sv
  - target: test
    files:
      - testbench/biquad_sva.sv
      - testbench/tb_biquad.sv
